//--- include/display_consts.svh
// **************************************************
// Display constants
// **************************************************
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// FIFO depth, must stay a power of two
`define FIFO_ENTRIES 8
// One RGB pixel per FIFO word
`define PIXEL_WIDTH 24
// Word address into the frame buffer
`define MEM_ADDR_WIDTH 16

// Horizontal regions in pixels, 14 per line
`define H_ACTIVE 8
`define H_FRONT 2
`define H_SYNC 2
`define H_BACK 2

// Vertical regions in lines, 7 per frame
`define V_ACTIVE 4
`define V_FRONT 1
`define V_SYNC 1
`define V_BACK 1

`define FRAME_PIXELS (`H_ACTIVE * `V_ACTIVE)

`endif

//--- src/display_pkg.sv
// **************************************************
// Display types
// **************************************************
package display_pkg;

	// 24-bit RGB, also the FIFO word
	typedef struct packed
	{
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	// Registered video output toward the panel
	typedef struct packed
	{
		logic hsync;
		logic vsync;
		logic active;
		pixel_t pixel;
	} video_out_t;

	// Region of a line or of a frame
	// Shared by horizontal and vertical counters
	typedef enum logic [1:0]
	{
		ACTIVE,
		FRONT_PORCH,
		SYNC,
		BACK_PORCH
	} timing_state_e;

endpackage

//--- src/mem_pkg.sv
// **************************************************
// Memory port types
// **************************************************
`include "display_consts.svh"

package mem_pkg;

	// Frame buffer word address
	typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

	// Request carried to the memory port
	typedef struct packed
	{
		mem_addr_t addr;
	} mem_req_t;

	// Fetch engine states
	// Only one request in flight
	typedef enum logic
	{
		IDLE,
		WAIT_DATA
	} fetch_state_e;

endpackage

//--- src/async_fifo.sv
// **************************************************
// Dual-clock FIFO
// **************************************************
`timescale 1ns/1ns

module async_fifo
	#(
		parameter WIDTH = 32,
		parameter NUM_ENTRIES = 8
	)
	(
		// Read side
		input logic read_clock,
		input logic rst_n,
		input logic read_enable,
		output logic [WIDTH-1:0] read_data,
		output logic empty,

		// Write side
		input logic write_clock,
		input logic write_rst_n,
		input logic write_enable,
		output logic full,
		input logic [WIDTH-1:0] write_data
	);

	localparam ADDR_WIDTH = $clog2(NUM_ENTRIES);

	// Storage, written from the write domain only
	logic [WIDTH-1:0] fifo_data [NUM_ENTRIES];

	// Read domain state
	logic [ADDR_WIDTH-1:0] read_ptr;
	logic [ADDR_WIDTH-1:0] read_ptr_gray;
	logic [ADDR_WIDTH-1:0] write_ptr_sync0;
	logic [ADDR_WIDTH-1:0] write_ptr_sync1;

	// Write domain state
	logic [ADDR_WIDTH-1:0] write_ptr;
	logic [ADDR_WIDTH-1:0] write_ptr_gray;
	logic [ADDR_WIDTH-1:0] write_ptr_next;
	logic [ADDR_WIDTH-1:0] write_ptr_next_gray;
	logic [ADDR_WIDTH-1:0] read_ptr_sync0;
	logic [ADDR_WIDTH-1:0] read_ptr_sync1;

	// Gray forms, only one bit flips per step
	assign read_ptr_gray = read_ptr ^ (read_ptr >> 1);
	assign write_ptr_gray = write_ptr ^ (write_ptr >> 1);
	assign write_ptr_next = write_ptr + 1'b1;
	assign write_ptr_next_gray = write_ptr_next ^ (write_ptr_next >> 1);

	// Empty once the read pointer catches the synced write pointer
	assign empty = write_ptr_sync1 == read_ptr_gray;
	// Head word shows without a read latency
	assign read_data = fifo_data[read_ptr];

	// Full keeps one slot unused
	assign full = write_ptr_next_gray == read_ptr_sync1;

	// Read clock domain
	always_ff @(posedge read_clock)
	begin
		if (!rst_n)
		begin
			write_ptr_sync0 <= '0;
			write_ptr_sync1 <= '0;
			read_ptr <= '0;
		end
		else
		begin
			// Two-flop crossing of the write pointer
			write_ptr_sync0 <= write_ptr_gray;
			write_ptr_sync1 <= write_ptr_sync0;
			if (read_enable && !empty)
				read_ptr <= read_ptr + 1'b1;
		end
	end

	// Write clock domain pointers
	always_ff @(posedge write_clock)
	begin
		if (!write_rst_n)
		begin
			read_ptr_sync0 <= '0;
			read_ptr_sync1 <= '0;
			write_ptr <= '0;
		end
		else
		begin
			// Two-flop crossing of the read pointer
			read_ptr_sync0 <= read_ptr_gray;
			read_ptr_sync1 <= read_ptr_sync0;
			if (write_enable && !full)
				write_ptr <= write_ptr_next;
		end
	end

	// Storage write
	always_ff @(posedge write_clock)
	begin
		if (write_enable && !full)
			fifo_data[write_ptr] <= write_data;
	end

endmodule

//--- src/frame_fetch.sv
// **************************************************
// Frame buffer fetch engine
// **************************************************
`timescale 1ns/1ns
`include "display_consts.svh"

module frame_fetch
	(
		input logic mem_clock,
		input logic rst_n,
		input mem_pkg::mem_req_t fb_base,

		// Memory port
		output logic mem_req,
		output mem_pkg::mem_req_t mem_addr,
		input logic mem_data_valid,
		input display_pkg::pixel_t mem_data,

		// FIFO write side
		input logic full,
		output logic write_enable,
		output display_pkg::pixel_t write_data,
		output logic write_rst_n
	);

	import mem_pkg::*;

	// Position within one frame
	typedef logic [$clog2(`FRAME_PIXELS)-1:0] count_t;

	// Reset copy for the memory clock domain
	logic rst_sync0;
	logic rst_sync1;

	fetch_state_e state;
	count_t pixel_count;
	logic last_pixel;

	// Bring rst_n into mem_clock through two flops
	always_ff @(posedge mem_clock)
	begin
		rst_sync0 <= rst_n;
		rst_sync1 <= rst_sync0;
	end

	// FIFO write side shares the same reset copy
	assign write_rst_n = rst_sync1;

	// Returned word goes straight into the FIFO
	assign write_enable = (state == WAIT_DATA) && mem_data_valid;
	assign write_data = mem_data;

	// Final word of the frame
	assign last_pixel = pixel_count == count_t'(`FRAME_PIXELS - 1);

	always_ff @(posedge mem_clock)
	begin
		if (!rst_sync1)
		begin
			state <= IDLE;
			mem_req <= 1'b0;
			mem_addr <= fb_base;
			pixel_count <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Stale full only delays a request
					if (!full)
					begin
						mem_req <= 1'b1;
						state <= WAIT_DATA;
					end
				end

				WAIT_DATA:
				begin
					// Request is a single-cycle strobe
					mem_req <= 1'b0;
					if (mem_data_valid)
					begin
						state <= IDLE;
						if (last_pixel)
						begin
							// Wrap and pick up a new base
							pixel_count <= '0;
							mem_addr <= fb_base;
						end
						else
						begin
							pixel_count <= pixel_count + count_t'(1);
							mem_addr.addr <= mem_addr.addr + mem_addr_t'(1);
						end
					end
				end

				default:
				begin
					state <= IDLE;
					mem_req <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- src/video_timing.sv
// **************************************************
// Video timing generator
// **************************************************
`timescale 1ns/1ns
`include "display_consts.svh"

module video_timing
	(
		input logic read_clock,
		input logic rst_n,

		// FIFO read side
		output logic read_enable,
		input display_pkg::pixel_t read_data,
		input logic empty,

		// Panel side
		output display_pkg::video_out_t video_out,
		output logic underrun
	);

	import display_pkg::*;

	// Horizontal position
	timing_state_e h_state;
	logic [7:0] h_count;
	logic h_last;

	// Vertical position
	timing_state_e v_state;
	logic [7:0] v_count;
	logic v_last;

	// Last horizontal active pixel ends a line
	logic line_end;

	// Final count of a region
	function automatic logic [7:0] region_last(
		input timing_state_e region,
		input int active_len,
		input int front_len,
		input int sync_len,
		input int back_len);
		case (region)
			ACTIVE: return 8'(active_len - 1);
			FRONT_PORCH: return 8'(front_len - 1);
			SYNC: return 8'(sync_len - 1);
			default: return 8'(back_len - 1);
		endcase
	endfunction

	// Order front, sync, back, then active
	function automatic timing_state_e next_region(input timing_state_e region);
		case (region)
			FRONT_PORCH: return SYNC;
			SYNC: return BACK_PORCH;
			BACK_PORCH: return ACTIVE;
			default: return FRONT_PORCH;
		endcase
	endfunction

	assign h_last = h_count == region_last(h_state, `H_ACTIVE, `H_FRONT, `H_SYNC, `H_BACK);
	assign v_last = v_count == region_last(v_state, `V_ACTIVE, `V_FRONT, `V_SYNC, `V_BACK);
	assign line_end = h_last && (h_state == ACTIVE);

	// Pop exactly on visible pixels
	assign read_enable = (h_state == ACTIVE) && (v_state == ACTIVE);

	// Counters, starting in the front porch
	// First visible pixel lands 48 cycles after reset
	always_ff @(posedge read_clock)
	begin
		if (!rst_n)
		begin
			h_state <= FRONT_PORCH;
			h_count <= '0;
			v_state <= FRONT_PORCH;
			v_count <= '0;
		end
		else
		begin
			if (h_last)
			begin
				h_state <= next_region(h_state);
				h_count <= '0;
			end
			else
				h_count <= h_count + 8'd1;

			// Vertical steps once per line
			if (line_end)
			begin
				if (v_last)
				begin
					v_state <= next_region(v_state);
					v_count <= '0;
				end
				else
					v_count <= v_count + 8'd1;
			end
		end
	end

	// Output stage, one cycle behind the counters
	always_ff @(posedge read_clock)
	begin
		if (!rst_n)
		begin
			video_out <= '0;
			underrun <= 1'b0;
		end
		else
		begin
			video_out.hsync <= h_state == SYNC;
			video_out.vsync <= v_state == SYNC;
			video_out.active <= read_enable;
			// Black outside the visible area and on a starved FIFO
			video_out.pixel <= (read_enable && !empty) ? read_data : '0;
			// Sticky until the next reset
			if (read_enable && empty)
				underrun <= 1'b1;
		end
	end

endmodule

//--- src/display_top.sv
// **************************************************
// Display scan-out top
// **************************************************
`timescale 1ns/1ns
`include "display_consts.svh"

module display_top
	(
		input logic read_clock,
		input logic mem_clock,
		input logic rst_n,
		input mem_pkg::mem_req_t fb_base,

		// Memory port
		output logic mem_req,
		output mem_pkg::mem_req_t mem_addr,
		input logic mem_data_valid,
		input display_pkg::pixel_t mem_data,

		// Panel side
		output display_pkg::video_out_t video_out,
		output logic underrun
	);

	import display_pkg::*;

	// Memory clock side of the FIFO
	logic write_enable;
	pixel_t write_data;
	logic full;
	logic write_rst_n;

	// Pixel clock side of the FIFO
	logic read_enable;
	pixel_t read_data;
	logic empty;

	// Fills the FIFO from the frame buffer
	frame_fetch u_fetch
	(
		.mem_clock(mem_clock),
		.rst_n(rst_n),
		.fb_base(fb_base),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_data_valid(mem_data_valid),
		.mem_data(mem_data),
		.full(full),
		.write_enable(write_enable),
		.write_data(write_data),
		.write_rst_n(write_rst_n)
	);

	// Crossing from mem_clock to read_clock
	async_fifo
	#(
		.WIDTH(`PIXEL_WIDTH),
		.NUM_ENTRIES(`FIFO_ENTRIES)
	)
	u_fifo
	(
		.read_clock(read_clock),
		.rst_n(rst_n),
		.read_enable(read_enable),
		.read_data(read_data),
		.empty(empty),
		.write_clock(mem_clock),
		.write_rst_n(write_rst_n),
		.write_enable(write_enable),
		.full(full),
		.write_data(write_data)
	);

	// Sync, blanking and pixel pop
	video_timing u_timing
	(
		.read_clock(read_clock),
		.rst_n(rst_n),
		.read_enable(read_enable),
		.read_data(read_data),
		.empty(empty),
		.video_out(video_out),
		.underrun(underrun)
	);

endmodule

//--- tb/display_tb.sv
// **************************************************
// Display scan-out testbench
// **************************************************
`timescale 1ns/1ns
`include "display_consts.svh"

module display_tb;

	import display_pkg::*;
	import mem_pkg::*;

	localparam int LINE_CYCLES = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int FRAME_CYCLES = LINE_CYCLES * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
	// Blanking lines plus horizontal porches come before the first pixel
	localparam int FIRST_ACTIVE = LINE_CYCLES * (`V_FRONT + `V_SYNC + `V_BACK)
		+ `H_FRONT + `H_SYNC + `H_BACK;
	localparam int TRACE_CYCLES = 3 * FRAME_CYCLES;
	localparam int MEM_WORDS = 64;
	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (4 * FRAME_CYCLES + 200);

	// DUT ports
	logic read_clock;
	logic mem_clock;
	logic rst_n;
	mem_req_t fb_base;
	logic mem_req;
	mem_req_t mem_addr;
	logic mem_data_valid;
	pixel_t mem_data;
	video_out_t video_out;
	logic underrun;

	// Frame buffer model
	pixel_t memory [MEM_WORDS];
	int mem_latency;
	bit range_check_on;
	integer seed;

	// Video samples of one run, one per read_clock
	video_out_t trace_video [TRACE_CYCLES];
	logic trace_underrun [TRACE_CYCLES];
	pixel_t active_pixels [TRACE_CYCLES];
	int active_count;

	int check_count;
	int error_count;
	int cycle_count;

	display_top UUT
	(
		.read_clock(read_clock),
		.mem_clock(mem_clock),
		.rst_n(rst_n),
		.fb_base(fb_base),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_data_valid(mem_data_valid),
		.mem_data(mem_data),
		.video_out(video_out),
		.underrun(underrun)
	);

	// Pixel clock, 4 ns
	initial
	begin
		read_clock = 1'b0;
		forever #2 read_clock = ~read_clock;
	end

	// Memory clock, 2 ns
	// Three cycles per word keeps ahead of the pixel demand
	initial
	begin
		mem_clock = 1'b0;
		forever #1 mem_clock = ~mem_clock;
	end

	// Memory port model, one request in flight
	initial
	begin : memory_model
		logic req_seen;
		mem_addr_t addr_seen;
		mem_addr_t pending_addr;
		logic pending;
		int wait_count;
		int hold;
		mem_data_valid = 1'b0;
		mem_data = '0;
		pending = 1'b0;
		pending_addr = '0;
		wait_count = 0;
		hold = 3;
		forever
		begin
			// Requests are registered, so look at them mid-cycle
			@(negedge mem_clock);
			req_seen = mem_req;
			addr_seen = mem_addr.addr;
			@(posedge mem_clock);
			mem_data_valid <= 1'b0;
			if (!rst_n)
			begin
				// Drop anything in flight across a reset
				hold = 3;
				pending = 1'b0;
			end
			else if (hold != 0)
			begin
				// Fetch reset lags rst_n by its synchronizer
				hold = hold - 1;
				pending = 1'b0;
			end
			else if (pending)
			begin
				if (wait_count == 0)
				begin
					mem_data_valid <= 1'b1;
					mem_data <= memory[pending_addr[5:0]];
					pending = 1'b0;
				end
				else
					wait_count = wait_count - 1;
			end
			else if (req_seen)
			begin
				if (range_check_on)
				begin
					check_count++;
					if (addr_seen < 32 || addr_seen > 63)
						report_failure($sformatf("mem_addr 0x%0h left the frame at 0x20", addr_seen));
				end
				if (mem_latency <= 1)
				begin
					mem_data_valid <= 1'b1;
					mem_data <= memory[addr_seen[5:0]];
				end
				else
				begin
					pending = 1'b1;
					pending_addr = addr_seen;
					wait_count = mem_latency - 2;
				end
			end
		end
	end

	// Compare and count
	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("failure at %0t ns: %s", $time, what);
	endtask

	// New base and latency, then rst_n low for two pixel clocks
	task automatic apply_reset(input mem_addr_t base, input int latency);
		@(posedge mem_clock);
		fb_base.addr <= base;
		mem_latency <= latency;
		@(posedge read_clock);
		rst_n <= 1'b0;
		repeat (2) @(posedge read_clock);
		rst_n <= 1'b1;
	endtask

	// Sample the panel side at falling edges and pick out visible pixels
	task automatic record_video();
		int i;
		for (i = 0; i < TRACE_CYCLES; i++)
		begin
			@(negedge read_clock);
			trace_video[i] = video_out;
			trace_underrun[i] = underrun;
		end
		active_count = 0;
		for (i = 0; i < TRACE_CYCLES; i++)
		begin
			if (trace_video[i].active)
			begin
				active_pixels[active_count] = trace_video[i].pixel;
				active_count++;
			end
		end
	endtask

	// Visible pixel n is frame buffer word n of the frame at base
	task automatic compare_pixels(input int base, input int count);
		int n;
		if (active_count < count)
			report_failure($sformatf("only %0d visible pixels seen, %0d needed", active_count, count));
		else
			for (n = 0; n < count; n++)
				check_value($sformatf("pixel %0d", n), active_pixels[n],
					memory[(base + n % `FRAME_PIXELS) % MEM_WORDS]);
	endtask

	task automatic reset_state_test();
		apply_reset('0, 1);
		@(negedge read_clock);
		check_value("mem_req", mem_req, 1'b0);
		check_value("underrun", underrun, 1'b0);
		check_value("video_out", video_out, '0);
	endtask

	task automatic pixel_order_test();
		apply_reset('0, 1);
		record_video();
		compare_pixels(0, 2 * `FRAME_PIXELS);
		check_value("underrun", trace_underrun[TRACE_CYCLES - 1], 1'b0);
	endtask

	task automatic line_geometry_test();
		int i;
		int run;
		int last_rise;
		int rises;
		int first_active;
		apply_reset('0, 1);
		record_video();
		first_active = -1;
		run = 0;
		for (i = 0; i < TRACE_CYCLES; i++)
		begin
			if (trace_video[i].active && first_active < 0)
				first_active = i;
			if (trace_video[i].active)
				run++;
			else if (run != 0)
			begin
				check_value("active run length", run, `H_ACTIVE);
				run = 0;
			end
		end
		// Output register adds one sample
		check_value("first active sample", first_active, FIRST_ACTIVE + 1);
		run = 0;
		last_rise = -1;
		rises = 0;
		for (i = 1; i < TRACE_CYCLES; i++)
		begin
			if (trace_video[i].hsync && !trace_video[i - 1].hsync)
			begin
				if (last_rise >= 0)
					check_value("hsync edge spacing", i - last_rise, LINE_CYCLES);
				last_rise = i;
				rises++;
			end
			if (trace_video[i].hsync)
				run++;
			else if (run != 0)
			begin
				check_value("hsync pulse length", run, `H_SYNC);
				run = 0;
			end
		end
		if (rises < 2)
			report_failure("hsync never rose a second time");
	endtask

	task automatic frame_geometry_test();
		int i;
		int run;
		int last_rise;
		int rises;
		int lines;
		apply_reset('0, 1);
		record_video();
		run = 0;
		last_rise = -1;
		rises = 0;
		lines = 0;
		for (i = 1; i < TRACE_CYCLES; i++)
		begin
			// Lines with pixels since the last vsync edge
			if (trace_video[i].active && !trace_video[i - 1].active)
				lines++;
			if (trace_video[i].vsync && !trace_video[i - 1].vsync)
			begin
				if (last_rise >= 0)
				begin
					check_value("vsync edge spacing", i - last_rise, FRAME_CYCLES);
					check_value("active lines per frame", lines, `V_ACTIVE);
				end
				last_rise = i;
				rises++;
				lines = 0;
			end
			if (trace_video[i].vsync)
				run++;
			else if (run != 0)
			begin
				check_value("vsync pulse length", run, LINE_CYCLES);
				run = 0;
			end
		end
		if (rises < 2)
			report_failure("vsync never rose a second time");
	endtask

	task automatic base_address_test();
		apply_reset(16'd32, 1);
		range_check_on = 1'b1;
		record_video();
		range_check_on = 1'b0;
		compare_pixels(32, `FRAME_PIXELS);
	endtask

	task automatic underrun_test();
		int i;
		apply_reset('0, 12);
		record_video();
		// Set by the end of the first frame and held from then on
		for (i = FIRST_ACTIVE + FRAME_CYCLES; i < TRACE_CYCLES; i++)
			check_value("underrun", trace_underrun[i], 1'b1);
		apply_reset('0, 1);
		@(negedge read_clock);
		check_value("underrun after reset", underrun, 1'b0);
	endtask

	initial
	begin : test_sequence
		logic [31:0] word;
		rst_n = 1'b0;
		fb_base = '0;
		mem_latency = 1;
		range_check_on = 1'b0;
		check_count = 0;
		error_count = 0;
		seed = 32'h68ecb48e;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			word = $random(seed);
			memory[i] = word[23:0];
		end

		reset_state_test();
		pixel_order_test();
		line_geometry_test();
		frame_geometry_test();
		base_address_test();
		underrun_test();

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Run length limit in pixel clocks
	initial
	begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge read_clock);
			cycle_count++;
		end
		$display("timeout: tests still running after %0d read_clock cycles", TIMEOUT_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
src/display_pkg.sv
src/mem_pkg.sv
src/async_fifo.sv
src/frame_fetch.sv
src/video_timing.sv
src/display_top.sv
tb/display_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module display_tb -f vlog.f -o display_sim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/display_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
